// ==== Bender.yml ====
package:
  name: cpu

export_include_dirs:
  - hw

sources:
  - hw/cpu_pkg.sv
  - hw/regfile.sv
  - hw/fetch_unit.sv
  - hw/decoder.sv
  - hw/alu.sv
  - hw/execute_unit.sv
  - hw/cpu.sv
  - target: test
    files:
      - dv/cpu_checker.sv
      - dv/cpu_tb.sv

// ==== cpu.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/regfile.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/alu.sv
hw/execute_unit.sv
hw/cpu.sv
dv/cpu_checker.sv
dv/cpu_tb.sv

// ==== dv/cpu_checker.sv ====
`default_nettype none

module cpu_checker (
	input wire logic clk,
	input wire logic reset,
	input wire cpu_pkg::mem_write_t dwrite,
	input wire logic trap,
	input wire logic done,
	input wire logic [7:0] test_idx,
	input wire logic [15:0] exp_addr,
	input wire logic [7:0] exp_byte,
	input wire logic [7:0] exp_writes,
	input wire logic exp_trap,
	output int n_pass,
	output int n_fail
);
	int n_writes;
	int reset_cycles;
	logic trap_seen;
	logic reset_trap;
	logic bad_enable;
	logic [15:0] last_addr;
	logic [7:0] last_data;

	initial
	begin
		n_pass = 0;
		n_fail = 0;
		n_writes = 0;
		reset_cycles = 0;
		trap_seen = 1'b0;
		reset_trap = 1'b0;
		bad_enable = 1'b0;
	end

	task automatic evaluate_test();
		int errs;
		errs = reset_trap ? 1 : 0;
		if (bad_enable)
			errs++;
		if (exp_trap && !trap_seen)
		begin
			$display("test %0d: trap never asserted", test_idx);
			errs++;
		end
		if (!exp_trap && trap_seen)
		begin
			$display("test %0d: trap asserted although none was expected", test_idx);
			errs++;
		end
		if (exp_writes > 0 && n_writes == 0)
		begin
			$display("test %0d: no data write seen", test_idx);
			errs++;
		end
		else
		begin
			if (n_writes != exp_writes)
			begin
				$display("Fail at %0t: write count expected %0d got %0d",
					$time, exp_writes, n_writes);
				errs++;
			end
			// the last write carries the result of the program
			if (exp_writes > 0 && last_addr !== exp_addr)
			begin
				$display("Fail at %0t: dwrite.addr expected %h got %h",
					$time, exp_addr, last_addr);
				errs++;
			end
			if (exp_writes > 0 && last_data !== exp_byte)
			begin
				$display("Fail at %0t: dwrite.data expected %h got %h",
					$time, exp_byte, last_data);
				errs++;
			end
		end
		if (errs == 0)
		begin
			$display("test %0d ok", test_idx);
			n_pass++;
		end
		else
		begin
			$display("test %0d bad, %0d errors", test_idx, errs);
			n_fail++;
		end
		reset_trap = 1'b0;
		bad_enable = 1'b0;
	endtask

	always @(negedge clk)
	begin
		if (reset)
		begin
			// inst clears at the first edge of reset
			if (reset_cycles > 0 && trap !== 1'b0)
			begin
				$display("trap not low during reset at time %0t", $time);
				reset_trap = 1'b1;
			end
			if (reset_cycles > 0 && dwrite.en !== 2'b00)
			begin
				$display("Fail at %0t: dwrite.en expected 00 got %b", $time, dwrite.en);
				bad_enable = 1'b1;
			end
			reset_cycles++;
			n_writes = 0;
			trap_seen = 1'b0;
		end
		else
		begin
			reset_cycles = 0;
			// every kept store is a single byte
			if (dwrite.en[1] !== 1'b0)
			begin
				$display("Fail at %0t: dwrite.en[1] expected 0 got %b", $time, dwrite.en[1]);
				bad_enable = 1'b1;
			end
			if (dwrite.en[0])
			begin
				n_writes++;
				last_addr = dwrite.addr;
				last_data = dwrite.data[7:0];
			end
			if (trap)
				trap_seen = 1'b1;
		end
		if (done)
			evaluate_test();
	end
endmodule

`default_nettype wire

// ==== dv/cpu_tb.sv ====
`default_nettype none

`include "cpu_params.svh"

module cpu_tb;
	import cpu_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int NUM_TESTS = 26;
	localparam int MAX_RUN = 30;
	localparam logic [7:0] TRAP_BYTE = OP_TRAP;
	localparam logic [15:0] STACK_TOP = `CPU_RESET_SP - 16'd1;

	logic clk;
	logic reset;
	logic [15:0] iread_addr;
	inst_t iread_data;
	logic [15:0] dread_addr;
	logic [15:0] dread_data;
	mem_write_t dwrite;
	logic trap;

	logic done;
	logic [7:0] test_idx;
	logic [15:0] exp_addr;
	logic [7:0] exp_byte;
	logic [7:0] exp_writes;
	logic exp_trap;
	int n_pass;
	int n_fail;

	logic [7:0] prog_mem [8];
	logic [7:0] dmem [65536];
	logic [15:0] off0;
	logic [15:0] off1;
	logic [15:0] off2;
	integer seed;

	logic [7:0] prog_tab [NUM_TESTS][8];
	logic [15:0] addr_tab [NUM_TESTS];
	logic [7:0] byte_tab [NUM_TESTS];
	logic [7:0] writes_tab [NUM_TESTS];
	logic trap_tab [NUM_TESTS];
	int n_rows;

	cpu uut (.clk, .reset, .iread_addr, .iread_data, .dread_addr, .dread_data,
		.dwrite, .trap);

	cpu_checker chk (.clk, .reset, .dwrite, .trap, .done, .test_idx, .exp_addr,
		.exp_byte, .exp_writes, .exp_trap, .n_pass, .n_fail);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// bytes outside the loaded row read as trap
	assign off0 = iread_addr - `CPU_RESET_PC;
	assign off1 = off0 + 16'd1;
	assign off2 = off0 + 16'd2;
	assign iread_data = {
		(off2 < 16'd8) ? prog_mem[off2[2:0]] : TRAP_BYTE,
		(off1 < 16'd8) ? prog_mem[off1[2:0]] : TRAP_BYTE,
		(off0 < 16'd8) ? prog_mem[off0[2:0]] : TRAP_BYTE};

	// little-endian data port
	assign dread_data = {dmem[dread_addr + 16'd1], dmem[dread_addr]};

	always @(posedge clk)
	begin
		if (dwrite.en[0])
			dmem[dwrite.addr] <= dwrite.data[7:0];
		if (dwrite.en[1])
			dmem[dwrite.addr + 16'd1] <= dwrite.data[15:8];
	end

	task automatic add_row(input logic [7:0] b0, b1, b2, b3, b4, b5, b6, b7,
		input logic [15:0] addr, input logic [7:0] data, input logic [7:0] writes,
		input logic trap_exp);
		prog_tab[n_rows] = '{b0, b1, b2, b3, b4, b5, b6, b7};
		addr_tab[n_rows] = addr;
		byte_tab[n_rows] = data;
		writes_tab[n_rows] = writes;
		trap_tab[n_rows] = trap_exp;
		n_rows++;
	endtask

	task automatic build_table();
		// alu on immediates
		// c is clear after reset
		add_row(OP_LD_XL_IMM, 8'h3c, OP_ADD_IMM, 8'h25, OP_LD_DIR_XL, 8'h80, 8'h00, OP_TRAP,
			16'h0080, 8'h61, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'hf0, OP_ADC_IMM, 8'h20, OP_LD_DIR_XL, 8'h81, 8'h00, OP_TRAP,
			16'h0081, 8'h10, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'h50, OP_SUB_IMM, 8'h12, OP_LD_DIR_XL, 8'h82, 8'h00, OP_TRAP,
			16'h0082, 8'h3e, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'h50, OP_SBC_IMM, 8'h12, OP_LD_DIR_XL, 8'h83, 8'h00, OP_TRAP,
			16'h0083, 8'h3d, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'h5a, OP_AND_IMM, 8'h0f, OP_LD_DIR_XL, 8'h84, 8'h00, OP_TRAP,
			16'h0084, 8'h0a, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'h50, OP_OR_IMM, 8'h0a, OP_LD_DIR_XL, 8'h85, 8'h00, OP_TRAP,
			16'h0085, 8'h5a, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'hff, OP_XOR_IMM, 8'ha5, OP_LD_DIR_XL, 8'h86, 8'h00, OP_TRAP,
			16'h0086, 8'h5a, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'hff, OP_INC_XL, OP_LD_DIR_XL, 8'h87, 8'h00, OP_TRAP, OP_TRAP,
			16'h0087, 8'h00, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'h00, OP_DEC_XL, OP_LD_DIR_XL, 8'h88, 8'h00, OP_TRAP, OP_TRAP,
			16'h0088, 8'hff, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'h20, OP_ADD_DIR, 8'h20, 8'h03, OP_LD_DIR_XL, 8'h89, 8'h00,
			16'h0089, 8'h35, 1, 1'b1);
		// push stores a marker that shows whether the inc ran
		add_row(OP_LD_XL_IMM, 8'h42, OP_CP_IMM, 8'h42, OP_JRZ, 8'h01, OP_INC_XL, OP_PUSH_XL,
			STACK_TOP, 8'h42, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'h42, OP_CP_IMM, 8'h41, OP_JRZ, 8'h01, OP_INC_XL, OP_PUSH_XL,
			STACK_TOP, 8'h43, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'h42, OP_CP_IMM, 8'h41, OP_JRNZ, 8'h01, OP_INC_XL, OP_PUSH_XL,
			STACK_TOP, 8'h42, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'h42, OP_CP_IMM, 8'h41, OP_JRC, 8'h01, OP_INC_XL, OP_PUSH_XL,
			STACK_TOP, 8'h42, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'h41, OP_CP_IMM, 8'h42, OP_JRNC, 8'h01, OP_INC_XL, OP_PUSH_XL,
			STACK_TOP, 8'h41, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'h10, OP_SUB_IMM, 8'h20, OP_JRC, 8'h01, OP_INC_XL, OP_PUSH_XL,
			STACK_TOP, 8'hf1, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'h33, OP_SUB_IMM, 8'h33, OP_JRNZ, 8'h01, OP_INC_XL, OP_PUSH_XL,
			STACK_TOP, 8'h01, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'h42, OP_CP_IMM, 8'h41, OP_JRNC, 8'h01, OP_INC_XL, OP_PUSH_XL,
			STACK_TOP, 8'h43, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'h07, OP_JR, 8'h01, OP_INC_XL, OP_LD_DIR_XL, 8'h90, 8'h00,
			16'h0090, 8'h07, 1, 1'b1);
		// stack
		add_row(OP_LD_XL_IMM, 8'h5e, OP_PUSH_XL, OP_TRAP, OP_TRAP, OP_TRAP, OP_TRAP, OP_TRAP,
			STACK_TOP, 8'h5e, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'h77, OP_PUSH_XL, OP_DEC_XL, OP_POP_XL, OP_LD_DIR_XL, 8'h91,
			8'h00, 16'h0091, 8'h77, 2, 1'b1);
		// pointer access
		add_row(OP_LD_XL_IMM, 8'ha7, OP_LDW_Y_IMM, 8'h00, 8'h03, OP_LD_IY_XL, OP_TRAP, OP_TRAP,
			16'h0300, 8'ha7, 1, 1'b1);
		add_row(OP_LDW_Y_IMM, 8'h10, 8'h03, OP_LD_XL_IY, OP_LD_DIR_XL, 8'h92, 8'h00, OP_TRAP,
			16'h0092, 8'hc3, 1, 1'b1);
		// jumps over one push
		add_row(OP_LD_XL_IMM, 8'h3a, OP_JP_IMM, 8'h06, 8'h40, OP_PUSH_XL, OP_PUSH_XL, OP_TRAP,
			STACK_TOP, 8'h3a, 1, 1'b1);
		add_row(OP_LD_XL_IMM, 8'h3b, OP_LDW_Y_IMM, 8'h07, 8'h40, OP_JP_Y, OP_PUSH_XL,
			OP_PUSH_XL, STACK_TOP, 8'h3b, 1, 1'b1);
		// backward jr spins without reaching the trap
		add_row(OP_LD_XL_IMM, 8'h55, OP_LD_DIR_XL, 8'h93, 8'h00, OP_JR, 8'hfe, OP_TRAP,
			16'h0093, 8'h55, 1, 1'b0);
	endtask

	task automatic run_test(input int i);
		int cycles;
		@(posedge clk);
		#2;
		reset = 1'b1;
		for (int k = 0; k < 8; k++)
			prog_mem[k] = prog_tab[i][k];
		test_idx = i[7:0];
		exp_addr = addr_tab[i];
		exp_byte = byte_tab[i];
		exp_writes = writes_tab[i];
		exp_trap = trap_tab[i];
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (trap !== 1'b1 && cycles < MAX_RUN);
		@(posedge clk);
		#2;
		done = 1'b1;
		@(posedge clk);
		#2;
		done = 1'b0;
	endtask

	initial
	begin
		#(NUM_TESTS * 40 * CLK_PERIOD);
		$display("watchdog expired after %0d cycles", NUM_TESTS * 40);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		done = 1'b0;
		test_idx = '0;
		exp_addr = '0;
		exp_byte = '0;
		exp_writes = '0;
		exp_trap = 1'b0;
		n_rows = 0;
		seed = 39;
		for (int k = 0; k < 8; k++)
			prog_mem[k] = TRAP_BYTE;
		for (int a = 0; a < 65536; a++)
			dmem[a] = $random(seed);
		// source bytes for the direct add and the y load
		dmem[16'h0310] = 8'hc3;
		dmem[16'h0320] = 8'h15;
		build_table();

		for (int i = 0; i < NUM_TESTS; i++)
			run_test(i);

		$display("%0d tests, %0d ok, %0d bad", NUM_TESTS, n_pass, n_fail);
		if (n_fail == 0 && n_pass == NUM_TESTS)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end
endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`default_nettype none

`include "cpu_params.svh"

module alu (
	input wire cpu_pkg::alu_op_t op,
	input wire logic [`CPU_BYTE_W-1:0] a,
	input wire logic [`CPU_BYTE_W-1:0] b,
	input wire logic carry_in,
	output logic [`CPU_BYTE_W-1:0] result,
	output cpu_pkg::flags_t flags_out
);
	import cpu_pkg::*;

	// one extra bit catches carry or borrow
	logic [`CPU_BYTE_W:0] wide;
	logic carry;

	always_comb
	begin
		wide = '0;
		carry = carry_in;
		case (op)
			ALU_ADD:
			begin
				wide = {1'b0, a} + {1'b0, b};
				carry = wide[8];
			end
			ALU_ADC:
			begin
				wide = {1'b0, a} + {1'b0, b} + 9'(carry_in);
				carry = wide[8];
			end
			ALU_SUB:
			begin
				wide = {1'b0, a} - {1'b0, b};
				carry = !wide[8];
			end
			// c set means no borrow pending
			ALU_SBC:
			begin
				wide = {1'b0, a} - {1'b0, b} - 9'(!carry_in);
				carry = !wide[8];
			end
			ALU_INC:
			begin
				wide = {1'b0, a} + 9'd1;
				carry = wide[8];
			end
			ALU_DEC:
			begin
				wide = {1'b0, a} - 9'd1;
				carry = !wide[8];
			end
			ALU_AND:
			begin
				wide = {1'b0, a & b};
				carry = 1'b0;
			end
			ALU_OR:
			begin
				wide = {1'b0, a | b};
				carry = 1'b0;
			end
			ALU_XOR:
			begin
				wide = {1'b0, a ^ b};
				carry = 1'b0;
			end
			default:
				wide = {1'b0, b};
		endcase
	end

	assign result = wide[7:0];
	assign flags_out.z = (wide[7:0] == '0);
	assign flags_out.c = carry;
	assign flags_out.n = wide[7];
endmodule

`default_nettype wire

// ==== hw/cpu.sv ====
`default_nettype none

`include "cpu_params.svh"

module cpu (
	input wire logic clk,
	input wire logic reset,
	output logic [`CPU_WORD_W-1:0] iread_addr,
	input wire cpu_pkg::inst_t iread_data,
	output logic [`CPU_WORD_W-1:0] dread_addr,
	input wire logic [`CPU_WORD_W-1:0] dread_data,
	output cpu_pkg::mem_write_t dwrite,
	output logic trap
);
	import cpu_pkg::*;

	inst_t inst;
	inst_t next_inst;
	decode_t ctrl;
	flags_t next_flags;
	flags_t alu_flags;
	alu_op_t alu_op;
	logic [`CPU_BYTE_W-1:0] alu_a;
	logic [`CPU_BYTE_W-1:0] alu_b;
	logic [`CPU_BYTE_W-1:0] alu_result;
	logic alu_carry;
	reg_write_t reg_wr;
	logic [`CPU_WORD_W-1:0] x;
	logic [`CPU_WORD_W-1:0] y;
	logic [`CPU_WORD_W-1:0] next_y;

	fetch_unit fetch (.clk, .reset, .iread_data, .next_flags, .next_y,
		.iread_addr, .inst, .next_inst);

	decoder dec (.inst, .ctrl);

	execute_unit exec (.clk, .reset, .ctrl, .inst, .next_inst, .x, .y, .next_y,
		.dread_data, .alu_result, .alu_flags, .alu_op, .alu_a, .alu_b, .alu_carry,
		.next_flags, .dread_addr, .reg_wr, .dwrite, .trap);

	alu alu_i (.op(alu_op), .a(alu_a), .b(alu_b), .carry_in(alu_carry),
		.result(alu_result), .flags_out(alu_flags));

	// x lookahead has no consumer in this core
	regfile regs (.clk, .wr(reg_wr), .x, .y, .next_x(), .next_y);
endmodule

`default_nettype wire

// ==== hw/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// register and address width
`define CPU_WORD_W 16

// alu data width
`define CPU_BYTE_W 8

// opcode byte plus two operand bytes
`define CPU_INST_W 24

// first instruction fetched after reset
`define CPU_RESET_PC 16'h4000

// stack grows down from here
`define CPU_RESET_SP 16'h2000

// x and y
`define CPU_NUM_REGS 2

`endif

// ==== hw/cpu_pkg.sv ====
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

	typedef enum logic [7:0] {
		OP_ADD_IMM  = 8'h00,
		OP_ADC_IMM  = 8'h01,
		OP_SUB_IMM  = 8'h02,
		OP_SBC_IMM  = 8'h03,
		OP_AND_IMM  = 8'h04,
		OP_OR_IMM   = 8'h05,
		OP_XOR_IMM  = 8'h06,
		OP_CP_IMM   = 8'h07,
		OP_ADD_DIR  = 8'h08,
		OP_ADC_DIR  = 8'h09,
		OP_SUB_DIR  = 8'h0a,
		OP_SBC_DIR  = 8'h0b,
		OP_AND_DIR  = 8'h0c,
		OP_OR_DIR   = 8'h0d,
		OP_XOR_DIR  = 8'h0e,
		OP_CP_DIR   = 8'h0f,
		OP_INC_XL   = 8'h10,
		OP_DEC_XL   = 8'h11,
		OP_LD_XL_IMM = 8'h12,
		OP_LD_XL_DIR = 8'h13,
		OP_LD_DIR_XL = 8'h14,
		OP_LD_XL_IY  = 8'h15,
		OP_LD_IY_XL  = 8'h16,
		OP_LDW_Y_IMM = 8'h17,
		OP_PUSH_XL  = 8'h18,
		OP_POP_XL   = 8'h19,
		OP_JP_IMM   = 8'h1a,
		OP_JP_Y     = 8'h1b,
		OP_JR       = 8'h1c,
		OP_JRZ      = 8'h1d,
		OP_JRNZ     = 8'h1e,
		OP_JRC      = 8'h1f,
		OP_JRNC     = 8'h20,
		OP_TRAP     = 8'h21,
		OP_NOP      = 8'hff
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_AND,
		ALU_OR, ALU_XOR, ALU_INC, ALU_DEC, ALU_PASS
	} alu_op_t;

	typedef enum logic {B_IMM, B_DATA} b_src_t;
	typedef enum logic [1:0] {RW_NONE, RW_XL, RW_Y} reg_wr_t;
	typedef enum logic [1:0] {MW_NONE, MW_DIR, MW_IY, MW_PUSH} mem_wr_t;
	typedef enum logic [1:0] {MR_NONE, MR_DIR, MR_IY, MR_POP} mem_rd_t;
	typedef enum logic [1:0] {SP_KEEP, SP_DEC, SP_INC} sp_adj_t;

	typedef struct packed {
		logic z;
		logic c;
		logic n;
	} flags_t;

	// little-endian fetch, opcode sits in the low byte
	typedef struct packed {
		logic [`CPU_BYTE_W-1:0] hi;
		logic [`CPU_BYTE_W-1:0] lo;
		opcode_t opcode;
	} inst_t;

	typedef struct packed {
		logic [$clog2(`CPU_NUM_REGS)-1:0] idx;
		logic [1:0] en;
		logic [`CPU_WORD_W-1:0] data;
	} reg_write_t;

	typedef struct packed {
		logic [`CPU_WORD_W-1:0] addr;
		logic [1:0] en;
		logic [`CPU_WORD_W-1:0] data;
	} mem_write_t;

	typedef struct packed {
		alu_op_t alu_op;
		b_src_t b_src;
		logic flag_en;
		reg_wr_t reg_wr;
		mem_wr_t mem_wr;
		mem_rd_t mem_rd;
		sp_adj_t sp_adj;
	} decode_t;

endpackage

`default_nettype wire

// ==== hw/decoder.sv ====
`default_nettype none

module decoder (
	input wire cpu_pkg::inst_t inst,
	output cpu_pkg::decode_t ctrl
);
	import cpu_pkg::*;

	always_comb
	begin
		ctrl.alu_op = ALU_PASS;
		ctrl.b_src = B_IMM;
		ctrl.flag_en = 1'b0;
		ctrl.reg_wr = RW_NONE;
		ctrl.mem_wr = MW_NONE;
		ctrl.mem_rd = MR_NONE;
		ctrl.sp_adj = SP_KEEP;

		case (inst.opcode)
			OP_ADD_IMM, OP_ADD_DIR:
				ctrl.alu_op = ALU_ADD;
			OP_ADC_IMM, OP_ADC_DIR:
				ctrl.alu_op = ALU_ADC;
			// cp is a sub without write-back
			OP_SUB_IMM, OP_SUB_DIR, OP_CP_IMM, OP_CP_DIR:
				ctrl.alu_op = ALU_SUB;
			OP_SBC_IMM, OP_SBC_DIR:
				ctrl.alu_op = ALU_SBC;
			OP_AND_IMM, OP_AND_DIR:
				ctrl.alu_op = ALU_AND;
			OP_OR_IMM, OP_OR_DIR:
				ctrl.alu_op = ALU_OR;
			OP_XOR_IMM, OP_XOR_DIR:
				ctrl.alu_op = ALU_XOR;
			OP_INC_XL:
				ctrl.alu_op = ALU_INC;
			OP_DEC_XL:
				ctrl.alu_op = ALU_DEC;
			default:
				ctrl.alu_op = ALU_PASS;
		endcase

		case (inst.opcode)
			OP_ADD_IMM, OP_ADC_IMM, OP_SUB_IMM, OP_SBC_IMM,
			OP_AND_IMM, OP_OR_IMM, OP_XOR_IMM, OP_INC_XL, OP_DEC_XL:
			begin
				ctrl.flag_en = 1'b1;
				ctrl.reg_wr = RW_XL;
			end
			OP_ADD_DIR, OP_ADC_DIR, OP_SUB_DIR, OP_SBC_DIR,
			OP_AND_DIR, OP_OR_DIR, OP_XOR_DIR:
			begin
				ctrl.flag_en = 1'b1;
				ctrl.reg_wr = RW_XL;
				ctrl.b_src = B_DATA;
				ctrl.mem_rd = MR_DIR;
			end
			OP_CP_IMM:
				ctrl.flag_en = 1'b1;
			OP_CP_DIR:
			begin
				ctrl.flag_en = 1'b1;
				ctrl.b_src = B_DATA;
				ctrl.mem_rd = MR_DIR;
			end
			OP_LD_XL_IMM:
				ctrl.reg_wr = RW_XL;
			OP_LD_XL_DIR:
			begin
				ctrl.reg_wr = RW_XL;
				ctrl.b_src = B_DATA;
				ctrl.mem_rd = MR_DIR;
			end
			OP_LD_XL_IY:
			begin
				ctrl.reg_wr = RW_XL;
				ctrl.b_src = B_DATA;
				ctrl.mem_rd = MR_IY;
			end
			OP_POP_XL:
			begin
				ctrl.reg_wr = RW_XL;
				ctrl.b_src = B_DATA;
				ctrl.mem_rd = MR_POP;
				ctrl.sp_adj = SP_INC;
			end
			OP_LD_DIR_XL:
				ctrl.mem_wr = MW_DIR;
			OP_LD_IY_XL:
				ctrl.mem_wr = MW_IY;
			OP_PUSH_XL:
			begin
				ctrl.mem_wr = MW_PUSH;
				ctrl.sp_adj = SP_DEC;
			end
			OP_LDW_Y_IMM:
				ctrl.reg_wr = RW_Y;
			default:
				ctrl.reg_wr = RW_NONE;
		endcase
	end
endmodule

`default_nettype wire

// ==== hw/execute_unit.sv ====
`default_nettype none

`include "cpu_params.svh"

module execute_unit (
	input wire logic clk,
	input wire logic reset,
	input wire cpu_pkg::decode_t ctrl,
	input wire cpu_pkg::inst_t inst,
	input wire cpu_pkg::inst_t next_inst,
	input wire logic [`CPU_WORD_W-1:0] x,
	input wire logic [`CPU_WORD_W-1:0] y,
	input wire logic [`CPU_WORD_W-1:0] next_y,
	input wire logic [`CPU_WORD_W-1:0] dread_data,
	input wire logic [`CPU_BYTE_W-1:0] alu_result,
	input wire cpu_pkg::flags_t alu_flags,
	output cpu_pkg::alu_op_t alu_op,
	output logic [`CPU_BYTE_W-1:0] alu_a,
	output logic [`CPU_BYTE_W-1:0] alu_b,
	output logic alu_carry,
	output cpu_pkg::flags_t next_flags,
	output logic [`CPU_WORD_W-1:0] dread_addr,
	output cpu_pkg::reg_write_t reg_wr,
	output cpu_pkg::mem_write_t dwrite,
	output logic trap
);
	import cpu_pkg::*;

	flags_t flags;
	logic [`CPU_WORD_W-1:0] sp;
	logic [`CPU_WORD_W-1:0] next_sp;
	logic [`CPU_BYTE_W-1:0] rd_byte;

	always_comb
	begin
		case (ctrl.sp_adj)
			SP_DEC:
				next_sp = sp - 16'd1;
			SP_INC:
				next_sp = sp + 16'd1;
			default:
				next_sp = sp;
		endcase
	end

	assign next_flags = ctrl.flag_en ? alu_flags : flags;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			flags <= '0;
			sp <= `CPU_RESET_SP;
		end
		else
		begin
			flags <= next_flags;
			sp <= next_sp;
		end
	end

	// address for the incoming instruction from lookahead register values
	always_comb
	begin
		case (next_inst.opcode)
			OP_ADD_DIR, OP_ADC_DIR, OP_SUB_DIR, OP_SBC_DIR,
			OP_AND_DIR, OP_OR_DIR, OP_XOR_DIR, OP_CP_DIR, OP_LD_XL_DIR:
				dread_addr = {next_inst.hi, next_inst.lo};
			OP_LD_XL_IY:
				dread_addr = next_y;
			OP_POP_XL:
				dread_addr = next_sp;
			default:
				dread_addr = '0;
		endcase
	end

	// data byte held for the next instruction; a store at the same edge wins
	always_ff @(posedge clk)
	begin
		if (dwrite.en[0] && dwrite.addr == dread_addr)
			rd_byte <= dwrite.data[7:0];
		else
			rd_byte <= dread_data[7:0];
	end

	assign alu_op = ctrl.alu_op;
	assign alu_a = x[7:0];
	assign alu_b = (ctrl.b_src == B_IMM) ? inst.lo : rd_byte;
	assign alu_carry = flags.c;

	always_comb
	begin
		case (ctrl.reg_wr)
			RW_XL:
			begin
				reg_wr.idx = 1'b0;
				reg_wr.en = 2'b01;
				reg_wr.data = {x[15:8], alu_result};
			end
			RW_Y:
			begin
				reg_wr.idx = 1'b1;
				reg_wr.en = 2'b11;
				reg_wr.data = {inst.hi, inst.lo};
			end
			default:
			begin
				reg_wr.idx = 1'b0;
				reg_wr.en = 2'b00;
				reg_wr.data = '0;
			end
		endcase
	end

	always_comb
	begin
		dwrite.en = (ctrl.mem_wr == MW_NONE) ? 2'b00 : 2'b01;
		dwrite.data = {8'h00, x[7:0]};
		case (ctrl.mem_wr)
			MW_DIR:
				dwrite.addr = {inst.hi, inst.lo};
			MW_IY:
				dwrite.addr = y;
			MW_PUSH:
				dwrite.addr = sp - 16'd1;
			default:
				dwrite.addr = '0;
		endcase
	end

	assign trap = (inst.opcode == OP_TRAP);
endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`default_nettype none

`include "cpu_params.svh"

module fetch_unit (
	input wire logic clk,
	input wire logic reset,
	input wire cpu_pkg::inst_t iread_data,
	input wire cpu_pkg::flags_t next_flags,
	input wire logic [`CPU_WORD_W-1:0] next_y,
	output logic [`CPU_WORD_W-1:0] iread_addr,
	output cpu_pkg::inst_t inst,
	output cpu_pkg::inst_t next_inst
);
	import cpu_pkg::*;

	// address of the instruction being fetched
	logic [`CPU_WORD_W-1:0] pc;
	logic [`CPU_WORD_W-1:0] next_pc;
	logic [`CPU_WORD_W-1:0] seq_pc;
	logic [`CPU_WORD_W-1:0] offset;
	logic taken;

	function automatic logic [1:0] inst_len(opcode_t op);
		case (op)
			OP_ADD_IMM, OP_ADC_IMM, OP_SUB_IMM, OP_SBC_IMM,
			OP_AND_IMM, OP_OR_IMM, OP_XOR_IMM, OP_CP_IMM,
			OP_LD_XL_IMM, OP_JR, OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC:
				inst_len = 2'd2;
			OP_ADD_DIR, OP_ADC_DIR, OP_SUB_DIR, OP_SBC_DIR,
			OP_AND_DIR, OP_OR_DIR, OP_XOR_DIR, OP_CP_DIR,
			OP_LD_XL_DIR, OP_LD_DIR_XL, OP_LDW_Y_IMM, OP_JP_IMM:
				inst_len = 2'd3;
			default:
				inst_len = 2'd1;
		endcase
	endfunction

	assign next_inst = iread_data;
	assign iread_addr = pc;

	assign seq_pc = pc + `CPU_WORD_W'(inst_len(next_inst.opcode));
	assign offset = {{8{next_inst.lo[7]}}, next_inst.lo};

	// conditions see the flags left by the instruction ahead
	always_comb
	begin
		case (next_inst.opcode)
			OP_JR:
				taken = 1'b1;
			OP_JRZ:
				taken = next_flags.z;
			OP_JRNZ:
				taken = !next_flags.z;
			OP_JRC:
				taken = next_flags.c;
			OP_JRNC:
				taken = !next_flags.c;
			default:
				taken = 1'b0;
		endcase
	end

	always_comb
	begin
		if (reset)
			next_pc = `CPU_RESET_PC;
		else if (next_inst.opcode == OP_JP_IMM)
			next_pc = {next_inst.hi, next_inst.lo};
		else if (next_inst.opcode == OP_JP_Y)
			next_pc = next_y;
		else if (taken)
			// offset counts from the byte after the branch
			next_pc = seq_pc + offset;
		else
			next_pc = seq_pc;
	end

	always_ff @(posedge clk)
		pc <= next_pc;

	always_ff @(posedge clk)
	begin
		if (reset)
			inst <= '{hi: '0, lo: '0, opcode: OP_NOP};
		else
			inst <= next_inst;
	end
endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`default_nettype none

`include "cpu_params.svh"

module regfile (
	input wire logic clk,
	input wire cpu_pkg::reg_write_t wr,
	output logic [`CPU_WORD_W-1:0] x,
	output logic [`CPU_WORD_W-1:0] y,
	output logic [`CPU_WORD_W-1:0] next_x,
	output logic [`CPU_WORD_W-1:0] next_y
);
	import cpu_pkg::*;

	logic [`CPU_WORD_W-1:0] regs [`CPU_NUM_REGS];
	logic [`CPU_WORD_W-1:0] next_regs [`CPU_NUM_REGS];

	// value after the pending write, for addressing the next instruction
	always_comb
	begin
		for (int i = 0; i < `CPU_NUM_REGS; i++)
		begin
			next_regs[i] = regs[i];
			if (wr.idx == i && wr.en[0])
				next_regs[i][7:0] = wr.data[7:0];
			if (wr.idx == i && wr.en[1])
				next_regs[i][15:8] = wr.data[15:8];
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr.en[0])
			regs[wr.idx][7:0] <= wr.data[7:0];
		if (wr.en[1])
			regs[wr.idx][15:8] <= wr.data[15:8];
	end

	assign x = regs[0];
	assign y = regs[1];
	assign next_x = next_regs[0];
	assign next_y = next_regs[1];
endmodule

`default_nettype wire
